//--- common/icachePkg.sv
`default_nettype none

package icachePkg;

  // bus and instruction widths
  localparam int AddrWidth = 32;
  localparam int WordWidth = 32;

  // line geometry
  localparam int WordsPerLine = 4;
  localparam int CacheSets = 16;

  // address fields are tag, index, word offset and byte
  localparam int WordOffBits = $clog2(WordsPerLine);
  localparam int OffsetBits = WordOffBits + 2;
  localparam int IndexBits = $clog2(CacheSets);
  localparam int TagBits = AddrWidth - IndexBits - OffsetBits;

  // top nibble of a cacheable fetch
  localparam logic [3:0] CachedRegion = 4'h8;

  typedef logic [WordsPerLine-1:0][WordWidth-1:0] line_t;

  typedef struct packed {
    logic [IndexBits-1:0] index;
    logic [TagBits-1:0] tag;
    logic [WordOffBits-1:0] offset;
  } lookup_t;

  typedef struct packed {
    logic [IndexBits-1:0] index;
    logic [TagBits-1:0] tag;
    line_t line;
  } fill_t;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic [AddrWidth-1:0] adr;
  } wbReq_t;

endpackage

`default_nettype wire

//--- icache/icacheWay.sv
`timescale 1ns/1ps
`default_nettype none

module icacheWay #(
  parameter int NumSets = icachePkg::CacheSets
) (
  input wire clk,
  input wire rst_n,
  input wire icachePkg::lookup_t lookup_i,
  input wire icachePkg::fill_t fill_i,
  input wire fillEn_i,
  output logic hit_o,
  output icachePkg::line_t line_o
);

  import icachePkg::*;

  logic [NumSets-1:0] validBits;
  logic [TagBits-1:0] tagArray [NumSets];
  line_t lineArray [NumSets];

  logic entryValid;
  logic tagMatch;

  // a fill marks its set valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (fillEn_i) begin
      validBits[fill_i.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArray[fill_i.index] <= fill_i.tag;
      lineArray[fill_i.index] <= fill_i.line;
    end
  end

  // asynchronous read at the lookup index
  assign entryValid = validBits[lookup_i.index];
  assign tagMatch = (tagArray[lookup_i.index] == lookup_i.tag);

  assign hit_o = entryValid && tagMatch;
  assign line_o = lineArray[lookup_i.index];

endmodule

`default_nettype wire

//--- icache/icacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module icacheCtrl #(
  parameter int NumWays = 2,
  parameter int NumSets = icachePkg::CacheSets
) (
  input wire clk,
  input wire rst_n,
  input wire reqValid_i,
  input wire [icachePkg::AddrWidth-1:0] reqAddr_i,
  input wire anyHit_i,
  input wire [icachePkg::WordWidth-1:0] wbDat_i,
  input wire wbAck_i,
  output logic reqReady_o,
  output logic rspValid_o,
  output icachePkg::lookup_t lookup_o,
  output icachePkg::fill_t fill_o,
  output logic [NumWays-1:0] fillEn_o,
  output logic useBuffer_o,
  output icachePkg::line_t buffer_o,
  output icachePkg::wbReq_t wb_o
);

  import icachePkg::*;

  localparam int WayBits = (NumWays > 1) ? $clog2(NumWays) : 1;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    Refill,
    Fill,
    Respond,
    Uncached
  } state_t;

  state_t state;
  state_t nextState;

  logic [AddrWidth-1:0] addrQ;
  logic [WordOffBits-1:0] beatCnt;
  line_t buffer;

  // shadow of the way valid bits for victim choice
  logic [NumWays-1:0] shadowValid [NumSets];
  logic [WayBits-1:0] rrPtr [NumSets];

  logic [IndexBits-1:0] reqIndex;
  logic [TagBits-1:0] reqTag;
  logic [WordOffBits-1:0] reqOffset;
  logic cachedReq;
  logic lookupHit;
  logic lastBeat;
  logic [WayBits-1:0] victim;
  logic victimFound;

  assign reqTag = addrQ[AddrWidth-1 -: TagBits];
  assign reqIndex = addrQ[OffsetBits +: IndexBits];
  assign reqOffset = addrQ[2 +: WordOffBits];
  assign cachedReq = (addrQ[AddrWidth-1 -: 4] == CachedRegion);

  assign lookupHit = (state == Lookup) && cachedReq && anyHit_i;
  assign lastBeat = wbAck_i && (beatCnt == WordOffBits'(WordsPerLine - 1));

  assign reqReady_o = (state == Idle) || lookupHit;
  assign rspValid_o = lookupHit || (state == Respond);
  assign useBuffer_o = (state == Respond);
  assign buffer_o = buffer;

  // uncached word sits in slot zero
  assign lookup_o.index = reqIndex;
  assign lookup_o.tag = reqTag;
  assign lookup_o.offset = cachedReq ? reqOffset : '0;

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (reqValid_i) begin
          nextState = Lookup;
        end
      end
      Lookup: begin
        if (!cachedReq) begin
          nextState = Uncached;
        end else if (anyHit_i) begin
          nextState = reqValid_i ? Lookup : Idle;
        end else begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (lastBeat) begin
          nextState = Fill;
        end
      end
      Fill: nextState = Respond;
      Respond: nextState = Idle;
      Uncached: begin
        if (wbAck_i) begin
          nextState = Respond;
        end
      end
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
      beatCnt <= '0;
    end else begin
      state <= nextState;
      // wraps back to zero after the last beat
      if (state == Refill && wbAck_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      addrQ <= reqAddr_i;
    end
    if (state == Refill && wbAck_i) begin
      buffer[beatCnt] <= wbDat_i;
    end else if (state == Uncached && wbAck_i) begin
      buffer[0] <= wbDat_i;
    end
  end

  // lowest invalid way first or else the set's pointer
  always_comb begin
    victim = rrPtr[reqIndex];
    victimFound = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (!victimFound && !shadowValid[reqIndex][w]) begin
        victim = WayBits'(w);
        victimFound = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NumSets; s++) begin
        shadowValid[s] <= '0;
        rrPtr[s] <= '0;
      end
    end else if (state == Fill) begin
      shadowValid[reqIndex][victim] <= 1'b1;
      // with two ways this is a plain flip
      if (rrPtr[reqIndex] == WayBits'(NumWays - 1)) begin
        rrPtr[reqIndex] <= '0;
      end else begin
        rrPtr[reqIndex] <= rrPtr[reqIndex] + 1'b1;
      end
    end
  end

  assign fillEn_o = (state == Fill) ? (NumWays'(1) << victim) : '0;
  assign fill_o.index = reqIndex;
  assign fill_o.tag = reqTag;
  assign fill_o.line = buffer;

  // cyc and stb stay up across all refill beats
  assign wb_o.cyc = (state == Refill) || (state == Uncached);
  assign wb_o.stb = (state == Refill) || (state == Uncached);
  assign wb_o.adr = (state == Refill) ? {addrQ[AddrWidth-1:OffsetBits], beatCnt, 2'b00} : addrQ;

endmodule

`default_nettype wire

//--- icache/wayMerge.sv
`timescale 1ns/1ps
`default_nettype none

module wayMerge #(
  parameter int NumWays = 2
) (
  input wire icachePkg::lookup_t lookup_i,
  input wire [NumWays-1:0] hits_i,
  input wire icachePkg::line_t [NumWays-1:0] lines_i,
  input wire useBuffer_i,
  input wire icachePkg::line_t buffer_i,
  output logic anyHit_o,
  output logic [icachePkg::WordWidth-1:0] rspData_o
);

  import icachePkg::*;

  line_t hitLine;
  line_t selLine;

  // and-or select since at most one way hits
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (hits_i[w]) begin
        hitLine = hitLine | lines_i[w];
      end
    end
  end

  assign anyHit_o = |hits_i;

  // refill buffer wins on the response after a fill or uncached read
  assign selLine = useBuffer_i ? buffer_i : hitLine;

  assign rspData_o = selLine[lookup_i.offset];

endmodule

`default_nettype wire

//--- hw/icacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTop #(
  parameter int NumWays = 2,
  parameter int NumSets = icachePkg::CacheSets
) (
  input wire clk,
  input wire rst_n,
  input wire reqValid_i,
  input wire [icachePkg::AddrWidth-1:0] reqAddr_i,
  input wire [icachePkg::WordWidth-1:0] wbDat_i,
  input wire wbAck_i,
  output wire reqReady_o,
  output wire rspValid_o,
  output wire [icachePkg::WordWidth-1:0] rspData_o,
  output wire icachePkg::wbReq_t wb_o
);

  import icachePkg::*;

  wire lookup_t lookup;
  wire fill_t fill;
  wire [NumWays-1:0] fillEn;
  wire [NumWays-1:0] wayHits;
  wire line_t [NumWays-1:0] wayLines;
  wire anyHit;
  wire useBuffer;
  wire line_t refillBuffer;

  icacheCtrl #(
    .NumWays(NumWays),
    .NumSets(NumSets)
  ) ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .reqValid_i(reqValid_i),
    .reqAddr_i(reqAddr_i),
    .anyHit_i(anyHit),
    .wbDat_i(wbDat_i),
    .wbAck_i(wbAck_i),
    .reqReady_o(reqReady_o),
    .rspValid_o(rspValid_o),
    .lookup_o(lookup),
    .fill_o(fill),
    .fillEn_o(fillEn),
    .useBuffer_o(useBuffer),
    .buffer_o(refillBuffer),
    .wb_o(wb_o)
  );

  // one instance per way sharing the lookup and fill buses
  for (genvar w = 0; w < NumWays; w++) begin : gWay
    icacheWay #(
      .NumSets(NumSets)
    ) way (
      .clk(clk),
      .rst_n(rst_n),
      .lookup_i(lookup),
      .fill_i(fill),
      .fillEn_i(fillEn[w]),
      .hit_o(wayHits[w]),
      .line_o(wayLines[w])
    );
  end

  wayMerge #(
    .NumWays(NumWays)
  ) merge (
    .lookup_i(lookup),
    .hits_i(wayHits),
    .lines_i(wayLines),
    .useBuffer_i(useBuffer),
    .buffer_i(refillBuffer),
    .anyHit_o(anyHit),
    .rspData_o(rspData_o)
  );

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int HalfPeriod = 5,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/icacheChecker.sv
`timescale 1ns/1ps
`default_nettype none

module icacheChecker #(
  parameter int NumWays = 2,
  parameter int NumSets = 16,
  parameter int MaxLatency = 25
) (
  input wire clk,
  input wire rst_n,
  input wire reqValid_i,
  input wire reqReady_i,
  input wire [icachePkg::AddrWidth-1:0] reqAddr_i,
  input wire rspValid_i,
  input wire [icachePkg::WordWidth-1:0] rspData_i,
  input wire icachePkg::wbReq_t wb_i,
  input wire wbAck_i,
  input wire allDone_i,
  output int fetchesDone_o,
  output int errors_o
);

  import icachePkg::*;

  localparam logic [31:0] MemXor = 32'h5a5a_c3c3;
  localparam int KindHit = 0;
  localparam int KindMiss = 1;
  localparam int KindUncached = 2;

  // reference cache with valid, tag and round-robin pointer per set
  logic refValid [NumSets][NumWays];
  logic [TagBits-1:0] refTag [NumSets][NumWays];
  int refPtr [NumSets];

  logic pending;
  logic [AddrWidth-1:0] pendAddr;
  int pendKind;
  int beats;
  int acceptCycle;
  int errAtAccept;
  int cycle;
  int errCount;
  int testCount;
  int testFails;
  int doneCount;
  logic resetChecked;
  logic totalsShown;
  logic prevOpen;
  logic [AddrWidth-1:0] prevAdr;

  function automatic string kindName(int kind);
    string name;
    case (kind)
      KindHit: name = "hit";
      KindMiss: name = "miss";
      default: name = "uncached";
    endcase
    return name;
  endfunction

  function automatic int findWay(logic [AddrWidth-1:0] addr);
    logic [IndexBits-1:0] idx;
    int hitWay;
    idx = addr[OffsetBits +: IndexBits];
    hitWay = -1;
    for (int w = 0; w < NumWays; w++) begin
      if (refValid[idx][w] && refTag[idx][w] == addr[AddrWidth-1 -: TagBits]) begin
        hitWay = w;
      end
    end
    return hitWay;
  endfunction

  task automatic flagError(input string msg);
    $display("%s", msg);
    errCount++;
  endtask

  // victim is the lowest invalid way or else the pointer
  // the pointer advances on every fill
  task automatic fillLine(input logic [AddrWidth-1:0] addr);
    logic [IndexBits-1:0] idx;
    int victim;
    idx = addr[OffsetBits +: IndexBits];
    victim = refPtr[idx];
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!refValid[idx][w]) begin
        victim = w;
      end
    end
    refValid[idx][victim] = 1'b1;
    refTag[idx][victim] = addr[AddrWidth-1 -: TagBits];
    refPtr[idx] = (refPtr[idx] + 1) % NumWays;
  endtask

  task automatic checkBus();
    logic [AddrWidth-1:0] expAdr;
    if (wb_i.stb && !wb_i.cyc) begin
      flagError($sformatf("Bus error at %0t: stb raised without cyc", $time));
    end
    if (wb_i.cyc && (!pending || pendKind == KindHit)) begin
      flagError($sformatf("Bus error at %0t: bus cycle with no miss or uncached fetch open",
                          $time));
    end
    if (prevOpen && !wb_i.stb) begin
      flagError($sformatf("Bus error at %0t: stb dropped before ack", $time));
    end else if (prevOpen && wb_i.adr != prevAdr) begin
      flagError($sformatf("Bus error at %0t: adr moved from %h to %h before ack",
                          $time, prevAdr, wb_i.adr));
    end
    if (wb_i.cyc && wb_i.stb && wbAck_i && pending) begin
      if (pendKind == KindMiss) begin
        expAdr = (pendAddr & ~32'(WordsPerLine * 4 - 1)) + 32'(beats) * 4;
      end else begin
        expAdr = pendAddr;
      end
      if (wb_i.adr != expAdr) begin
        flagError($sformatf("FAILED at %0t: bus read at %h, expected %h",
                            $time, wb_i.adr, expAdr));
      end
      beats++;
    end
    prevOpen = wb_i.stb && !wbAck_i;
    prevAdr = wb_i.adr;
  endtask

  task automatic finishFetch();
    int expBeats;
    logic [WordWidth-1:0] expData;
    if (!pending) begin
      flagError($sformatf("Protocol error at %0t: response with no fetch outstanding", $time));
    end else begin
      expData = pendAddr ^ MemXor;
      expBeats = (pendKind == KindMiss) ? WordsPerLine : ((pendKind == KindUncached) ? 1 : 0);
      if (rspData_i !== expData) begin
        flagError($sformatf("FAILED at %0t: fetch %h returned %h, expected %h",
                            $time, pendAddr, rspData_i, expData));
      end
      if (beats != expBeats) begin
        flagError($sformatf("Bus error at %0t: fetch %h made %0d reads instead of %0d",
                            $time, pendAddr, beats, expBeats));
      end
      if (pendKind == KindHit && cycle != acceptCycle + 1) begin
        flagError($sformatf("Timing error at %0t: hit on %h answered %0d cycles after accept",
                            $time, pendAddr, cycle - acceptCycle));
      end
      if (pendKind == KindMiss) begin
        fillLine(pendAddr);
      end
      testCount++;
      doneCount++;
      if (errCount != errAtAccept) begin
        testFails++;
      end
      $display("fetch %0d %s %h: %s", doneCount, kindName(pendKind), pendAddr,
               (errCount == errAtAccept) ? "ok" : "error");
      pending = 1'b0;
    end
  endtask

  task automatic startFetch();
    if (pending) begin
      flagError($sformatf("Protocol error at %0t: fetch accepted while one is open", $time));
    end
    pending = 1'b1;
    pendAddr = reqAddr_i;
    beats = 0;
    acceptCycle = cycle;
    errAtAccept = errCount;
    if (reqAddr_i[AddrWidth-1 -: 4] != CachedRegion) begin
      pendKind = KindUncached;
    end else if (findWay(reqAddr_i) >= 0) begin
      pendKind = KindHit;
    end else begin
      pendKind = KindMiss;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < NumSets; s++) begin
        refPtr[s] = 0;
        for (int w = 0; w < NumWays; w++) begin
          refValid[s][w] = 1'b0;
        end
      end
      pending = 1'b0;
      cycle = 0;
      errCount = 0;
      testCount = 0;
      testFails = 0;
      doneCount = 0;
      resetChecked = 1'b0;
      totalsShown = 1'b0;
      prevOpen = 1'b0;
    end else begin
      cycle++;
      // first cycle out of reset
      if (!resetChecked) begin
        resetChecked = 1'b1;
        testCount++;
        if (rspValid_i || wb_i.cyc || wb_i.stb || !reqReady_i) begin
          flagError($sformatf("Reset error at %0t: outputs not idle after reset", $time));
          testFails++;
          $display("reset state: error");
        end else begin
          $display("reset state: ok");
        end
      end
      checkBus();
      if (rspValid_i) begin
        finishFetch();
      end
      if (pending && cycle - acceptCycle > MaxLatency) begin
        flagError($sformatf("Missing response at %0t: fetch %h got no answer in %0d cycles",
                            $time, pendAddr, MaxLatency));
        pending = 1'b0;
      end
      if (reqValid_i && reqReady_i) begin
        startFetch();
      end
      if (allDone_i && !totalsShown) begin
        totalsShown = 1'b1;
        $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
                 testCount, testCount - testFails, testFails, errCount);
      end
    end
    fetchesDone_o <= doneCount;
    errors_o <= errCount;
  end

endmodule

`default_nettype wire

//--- verif/icacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTb;

  import icachePkg::*;

  localparam int NumWays = 2;
  localparam int NumSets = 16;
  localparam int NumRequests = 200;
  localparam int MaxWait = 3;
  // lookup, four beats of up to MaxWait + 2 cycles, fill, respond, idle and a bubble
  localparam int FetchCycles = WordsPerLine * (MaxWait + 2) + 5;
  localparam int CycleLimit = NumRequests * FetchCycles + 20;
  localparam logic [31:0] Seed = 32'hdbfb_0624;
  localparam logic [31:0] MemXor = 32'h5a5a_c3c3;

  wire clk;
  wire rst_n;
  logic reqValid;
  logic [AddrWidth-1:0] reqAddr;
  wire reqReady;
  wire rspValid;
  wire [WordWidth-1:0] rspData;
  wire wbReq_t wbReq;
  logic wbAck;
  logic [WordWidth-1:0] wbDat;
  logic allDone;
  int fetchesDone;
  int errorCount;
  int cycleCount;
  int issued;
  int waitLeft;
  integer stimSeed;
  integer waitSeed;

  tbClock #(
    .HalfPeriod(5),
    .ResetCycles(10)
  ) clockGen (
    .clk_o(clk),
    .rst_n_o(rst_n)
  );

  icacheTop #(
    .NumWays(NumWays),
    .NumSets(NumSets)
  ) UUT (
    .clk(clk),
    .rst_n(rst_n),
    .reqValid_i(reqValid),
    .reqAddr_i(reqAddr),
    .wbDat_i(wbDat),
    .wbAck_i(wbAck),
    .reqReady_o(reqReady),
    .rspValid_o(rspValid),
    .rspData_o(rspData),
    .wb_o(wbReq)
  );

  icacheChecker #(
    .NumWays(NumWays),
    .NumSets(NumSets),
    .MaxLatency(FetchCycles)
  ) respCheck (
    .clk(clk),
    .rst_n(rst_n),
    .reqValid_i(reqValid),
    .reqReady_i(reqReady),
    .reqAddr_i(reqAddr),
    .rspValid_i(rspValid),
    .rspData_i(rspData),
    .wb_i(wbReq),
    .wbAck_i(wbAck),
    .allDone_i(allDone),
    .fetchesDone_o(fetchesDone),
    .errors_o(errorCount)
  );

  // three tags over four sets keeps two-way sets under eviction pressure
  task automatic pickAddress(output logic [AddrWidth-1:0] addr);
    int tagSel;
    int setSel;
    int wordSel;
    tagSel = {$random(stimSeed)} % 3;
    setSel = {$random(stimSeed)} % 4;
    wordSel = {$random(stimSeed)} % WordsPerLine;
    if ({$random(stimSeed)} % 8 == 0) begin
      addr = 32'h0001_0000 | 32'(setSel << OffsetBits) | 32'(wordSel << 2);
    end else begin
      addr = 32'h8000_0000 | 32'(tagSel << 12) | 32'(setSel << OffsetBits)
             | 32'(wordSel << 2);
    end
  endtask

  initial begin : stimulus
    logic [AddrWidth-1:0] nextAddr;
    stimSeed = Seed;
    reqValid = 1'b0;
    reqAddr = '0;
    issued = 0;
    wait (rst_n === 1'b1);
    while (issued < NumRequests) begin
      @(posedge clk);
      if (!reqValid) begin
        pickAddress(nextAddr);
        reqValid <= 1'b1;
        reqAddr <= nextAddr;
      end else if (reqReady) begin
        issued++;
        pickAddress(nextAddr);
        // occasional one-cycle bubble between fetches
        if (issued < NumRequests && {$random(stimSeed)} % 5 != 0) begin
          reqAddr <= nextAddr;
        end else begin
          reqValid <= 1'b0;
        end
      end
    end
  end

  // wishbone slave with 0 to MaxWait wait states per beat
  initial begin : memoryModel
    waitSeed = ~Seed;
    wbAck = 1'b0;
    wbDat = '0;
    waitLeft = 0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        wbAck <= 1'b0;
        waitLeft <= 0;
      end else if (wbAck) begin
        wbAck <= 1'b0;
        waitLeft <= {$random(waitSeed)} % (MaxWait + 1);
      end else if (wbReq.cyc && wbReq.stb) begin
        if (waitLeft == 0) begin
          wbAck <= 1'b1;
          wbDat <= wbReq.adr ^ MemXor;
        end else begin
          waitLeft <= waitLeft - 1;
        end
      end
    end
  end

  initial begin : runControl
    allDone = 1'b0;
    cycleCount = 0;
    wait (rst_n === 1'b1);
    while (fetchesDone < NumRequests && cycleCount < CycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    if (fetchesDone < NumRequests) begin
      $display("Timeout after %0d cycles: only %0d of %0d fetches were answered",
               cycleCount, fetchesDone, NumRequests);
      $display("Simulation failed");
    end else begin
      allDone <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      if (errorCount == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icacheTop.f
common/icachePkg.sv
icache/icacheWay.sv
icache/icacheCtrl.sv
icache/wayMerge.sv
hw/icacheTop.sv
verif/tbClock.sv
verif/icacheChecker.sv
verif/icacheTb.sv

//--- run.sh
#!/bin/sh
# builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f icacheTop.f \
    --top-module icacheTb -Mdir "$BUILD_DIR" -o icacheSim; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$BUILD_DIR/icacheSim" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0
